// ==== run_sim.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module cpu_tb -o cpu_tb_sim

./obj_dir/cpu_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== sim/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker (
  input logic clk,
  input logic rst_n,
  input logic stall,
  input logic flush,
  input logic dmem_we,
  input logic dmem_re
);

  // a flush leaves a bubble in id_ex, so no load can stall the next cycle.
  flush_then_no_stall: assert property (
    @(posedge clk) disable iff (!rst_n) flush |=> !stall
  ) else $error("stall raised in the cycle after a flush");

  // the stall lets a bubble into execute, so it never lasts two cycles.
  stall_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) stall |=> !stall
  ) else $error("stall held for more than one cycle");

  // the instruction behind a taken branch must not reach the data memory.
  flush_squashes_access: assert property (
    @(posedge clk) disable iff (!rst_n) flush |=> !dmem_we && !dmem_re
  ) else $error("a squashed instruction reached the data memory");

endmodule

bind cpu_core cpu_checker cpu_checker_i (
  .clk(clk),
  .rst_n(rst_n),
  .stall(stall),
  .flush(flush),
  .dmem_we(dmem_we),
  .dmem_re(dmem_re)
);

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_tb import cpu_pkg::*; ();

  localparam int NUM_PROGRAMS = 20;
  localparam int BODY_END     = 48;               // first instruction of the store tail.
  localparam int HALT_ADDR    = BODY_END + 8;     // the jump to itself.
  localparam int RESET_CYCLES = 10;
  localparam int DRAIN_CYCLES = 8;
  localparam int PROG_CYCLES  = (HALT_ADDR + 1) * 4;
  localparam int CYCLE_LIMIT  =
    NUM_PROGRAMS * (PROG_CYCLES + DRAIN_CYCLES + RESET_CYCLES + 2);

  logic               clk;
  logic               rst_n;
  logic [`DATA_W-1:0] imem_addr;
  logic [`DATA_W-1:0] imem_rdata;
  logic [`DATA_W-1:0] dmem_addr;
  logic [`DATA_W-1:0] dmem_wdata;
  logic               dmem_we;
  logic               dmem_re;
  logic [`DATA_W-1:0] dmem_rdata;

  instr_t             imem [256];
  logic [`DATA_W-1:0] dmem [256];
  logic [`DATA_W-1:0] exp_addr[$];
  logic [`DATA_W-1:0] exp_data[$];
  int                 got_count;
  int                 prog_num;
  int                 cycles;
  integer             seed;

  cpu_core cpu_core_i (
    .clk(clk),
    .rst_n(rst_n),
    .imem_addr(imem_addr),
    .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_we(dmem_we),
    .dmem_re(dmem_re),
    .dmem_rdata(dmem_rdata)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // both memories answer in the same cycle.
  assign imem_rdata = imem[imem_addr[7:0]];
  assign dmem_rdata = dmem[dmem_addr[7:0]];

  // a store cycle never reads, so the written word is not sampled at this edge.
  always @(posedge clk) begin
    if (dmem_we)
      dmem[dmem_addr[7:0]] = dmem_wdata;
  end

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles in program %0d", cycles, prog_num);
      fail_run();
    end
  end

  // every store of the DUT is compared in order with the reference list.
  always @(negedge clk) begin
    if (rst_n && dmem_we) begin
      if (got_count >= exp_addr.size()) begin
        $display("program %0d made more stores than the reference model", prog_num);
        fail_run();
      end else begin
        assert ({dmem_addr, dmem_wdata} == {exp_addr[got_count], exp_data[got_count]})
        else begin
          $display("Error: program %0d store %0d expected addr %h data %h actual addr %h data %h",
                   prog_num, got_count, exp_addr[got_count], exp_data[got_count],
                   dmem_addr, dmem_wdata);
          fail_run();
        end
        got_count++;
      end
    end
  end

  function automatic logic [`DATA_W-1:0] fill_word(input int addr);
    logic [7:0] a;
    a = addr[7:0];
    return {a, ~a} ^ 16'h3c5a;
  endfunction

  function automatic instr_t make_r(input int funct, input int rd, input int rs, input int rt);
    instr_t w;
    w.r.opcode = OP_RTYPE;
    w.r.rs     = rs[2:0];
    w.r.rt     = rt[2:0];
    w.r.rd     = rd[2:0];
    w.r.funct  = funct[2:0];
    return w;
  endfunction

  function automatic instr_t make_i(input opcode_t op, input int rs, input int rt, input int imm);
    instr_t w;
    w.i.opcode = op;
    w.i.rs     = rs[2:0];
    w.i.rt     = rt[2:0];
    w.i.imm    = imm[5:0];
    return w;
  endfunction

  function automatic instr_t make_j(input int addr);
    instr_t w;
    w.j.opcode = OP_JMP;
    w.j.addr   = addr[11:0];
    return w;
  endfunction

  task next_rand(output int v, input int n);
    v = $unsigned($random(seed)) % n;
  endtask

  // dependent operands are picked often so forwarding and load-use get exercised.
  task build_program();
    int kind, v, rs, rt, rd, off, last_dest;
    for (int i = 0; i < 256; i++)
      imem[i] = 16'hf000;
    for (int i = 0; i < 8; i++) begin
      next_rand(v, 64);
      imem[i] = make_i(OP_ADDI, i, i, v - 32);
    end
    last_dest = 7;
    for (int i = 8; i < BODY_END; i++) begin
      next_rand(kind, 16);
      next_rand(rs, 8);
      next_rand(rt, 8);
      next_rand(rd, 8);
      next_rand(v, 2);
      if (v == 1)
        rs = last_dest;
      next_rand(off, 4);
      off = off + 1;
      if (i + 1 + off > BODY_END)
        off = BODY_END - i - 1;
      if (kind < 6 || kind == 15) begin
        next_rand(v, 6);
        imem[i] = make_r(v, rd, rs, rt);
        last_dest = rd;
      end else if (kind < 8) begin
        next_rand(v, 64);
        imem[i] = make_i(OP_ADDI, rs, rt, v - 32);
        last_dest = rt;
      end else if (kind < 10) begin
        next_rand(v, 64);
        imem[i] = make_i(OP_LW, rs, rt, v - 32);
        last_dest = rt;
      end else if (kind < 12) begin
        next_rand(v, 64);
        imem[i] = make_i(OP_SW, rd, last_dest, v - 32);
      end else if (kind == 12) begin
        imem[i] = make_i(OP_BEQ, rs, rt, off);
      end else if (kind == 13) begin
        imem[i] = make_i(OP_BNE, rs, rt, off);
      end else begin
        imem[i] = make_j(i + 1 + off);
      end
    end
    for (int i = 0; i < 8; i++)
      imem[BODY_END + i] = make_i(OP_SW, 0, i, i - 16);  // r0-relative dump of all registers.
    imem[HALT_ADDR] = make_j(HALT_ADDR);
  endtask

  task run_model();
    logic [`DATA_W-1:0] regs [8];
    logic [`DATA_W-1:0] mem [256];
    logic [`DATA_W-1:0] a, b, imm, addr;
    instr_t w;
    int pc, steps;
    for (int i = 0; i < 8; i++)
      regs[i] = '0;
    for (int i = 0; i < 256; i++)
      mem[i] = fill_word(i);
    exp_addr.delete();
    exp_data.delete();
    pc = 0;
    steps = 0;
    while (pc != HALT_ADDR && steps < 1000) begin
      w    = imem[pc];
      a    = regs[w.r.rs];
      b    = regs[w.r.rt];
      imm  = {{10{w.i.imm[5]}}, w.i.imm};
      addr = a + imm;
      pc   = pc + 1;
      case (w.r.opcode)
        OP_RTYPE: begin
          case (w.r.funct)
            3'd0: regs[w.r.rd] = a + b;
            3'd1: regs[w.r.rd] = a - b;
            3'd2: regs[w.r.rd] = a & b;
            3'd3: regs[w.r.rd] = a | b;
            3'd4: regs[w.r.rd] = a ^ b;
            3'd5: regs[w.r.rd] = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            default: ;
          endcase
        end
        OP_ADDI: regs[w.i.rt] = addr;
        OP_LW:   regs[w.i.rt] = mem[addr[7:0]];
        OP_SW: begin
          mem[addr[7:0]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        OP_BEQ: if (a == b) pc = pc + int'($signed(w.i.imm));
        OP_BNE: if (a != b) pc = pc + int'($signed(w.i.imm));
        OP_JMP: pc = int'(w.j.addr);
        default: ;
      endcase
      steps++;
    end
  endtask

  task run_program(input int p);
    int waited;
    @(posedge clk);
    #1 rst_n = 1'b0;
    prog_num  = p;
    got_count = 0;
    build_program();
    run_model();
    for (int i = 0; i < 256; i++)
      dmem[i] = fill_word(i);
    for (int c = 0; c < RESET_CYCLES + 1; c++) begin
      if (c == RESET_CYCLES) begin
        @(posedge clk);
        #1 rst_n = 1'b1;
      end
      @(negedge clk);
      assert (imem_addr == `DATA_W'(`RESET_PC) && !dmem_we && !dmem_re)
      else begin
        $display("Error: program %0d reset state expected pc %h we 0 re 0 actual pc %h we %b re %b",
                 p, `DATA_W'(`RESET_PC), imem_addr, dmem_we, dmem_re);
        fail_run();
      end
    end
    waited = 0;
    while (got_count < exp_addr.size() && waited < PROG_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    repeat (DRAIN_CYCLES) @(posedge clk);
    assert (got_count == exp_addr.size())
    else begin
      $display("Error: program %0d store count expected %0d actual %0d",
               p, exp_addr.size(), got_count);
      fail_run();
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    seed      = 32'h68a4_0f8d;
    cycles    = 0;
    got_count = 0;
    prog_num  = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 16'hf000;
      dmem[i] = fill_word(i);
    end
    for (int p = 0; p < NUM_PROGRAMS; p++)
      run_program(p);
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/pipeline_regs.sv
verilog/register_file.sv
verilog/decode_unit.sv
verilog/hazard_unit.sv
verilog/execute_unit.sv
verilog/cpu_core.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

// ==== verilog/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// one word is both the data width and the instruction width.
`define DATA_W 16
`define REG_ADDR_W 3
`define NUM_REGS 8
`define RESET_PC 0

`endif

// ==== verilog/cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_core import cpu_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  output logic [`DATA_W-1:0] imem_addr,
  input  logic [`DATA_W-1:0] imem_rdata,
  output logic [`DATA_W-1:0] dmem_addr,
  output logic [`DATA_W-1:0] dmem_wdata,
  output logic               dmem_we,
  output logic               dmem_re,
  input  logic [`DATA_W-1:0] dmem_rdata
);

  logic [`DATA_W-1:0] pc;
  logic [`DATA_W-1:0] pc_plus_1;
  logic               stall;
  logic               flush;
  fwd_sel_t           fwd_a;
  fwd_sel_t           fwd_b;

  instr_t                 id_instr;
  logic [`DATA_W-1:0]     id_pc_next;
  logic [`REG_ADDR_W-1:0] id_rs, id_rt, id_rd;
  logic [`DATA_W-1:0]     id_immediate, id_target, id_read_data_1, id_read_data_2;
  alu_op_t                id_alu_op;
  mem_op_t                id_mem_op;
  logic                   id_alu_src, id_reg_dst, id_reg_write, id_beq, id_bne, id_jump;

  logic [`REG_ADDR_W-1:0] ex_rs, ex_rt, ex_rd, ex_dest_reg;
  logic [`DATA_W-1:0]     ex_read_data_1, ex_read_data_2, ex_immediate, ex_target;
  logic [`DATA_W-1:0]     ex_alu_result, ex_store_data;
  alu_op_t                ex_alu_op;
  mem_op_t                ex_mem_op;
  logic                   ex_alu_src, ex_reg_dst, ex_reg_write, ex_beq, ex_bne, ex_jump;
  logic                   ex_take_branch;

  logic [`DATA_W-1:0]     mem_alu_result, mem_store_data, mem_target, mem_wb_data;
  logic [`REG_ADDR_W-1:0] mem_dest_reg;
  mem_op_t                mem_mem_op;
  logic                   mem_reg_write, mem_take_branch;

  logic [`DATA_W-1:0]     wb_data;
  logic [`REG_ADDR_W-1:0] wb_dest_reg;
  logic                   wb_reg_write;

  assign pc_plus_1 = pc + `DATA_W'(1);
  assign imem_addr = pc;

  // a redirect from the memory stage overrides a load-use stall.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      pc <= `DATA_W'(`RESET_PC);
    else if (flush)
      pc <= mem_target;
    else if (!stall)
      pc <= pc_plus_1;
  end

  assign flush       = mem_take_branch;
  assign dmem_addr   = mem_alu_result;
  assign dmem_wdata  = mem_store_data;
  assign dmem_we     = mem_mem_op == MEM_WRITE;
  assign dmem_re     = mem_mem_op == MEM_READ;
  assign mem_wb_data = dmem_re ? dmem_rdata : mem_alu_result;

  if_id_register if_id_i (
    .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
    .instr_in(imem_rdata), .pc_next_in(pc_plus_1),
    .instr_out(id_instr), .pc_next_out(id_pc_next)
  );

  decode_unit decode_i (
    .instr(id_instr), .pc_next(id_pc_next),
    .rs(id_rs), .rt(id_rt), .rd(id_rd),
    .immediate(id_immediate), .target(id_target),
    .alu_op(id_alu_op), .mem_op(id_mem_op), .alu_src(id_alu_src),
    .reg_dst(id_reg_dst), .reg_write(id_reg_write),
    .beq(id_beq), .bne(id_bne), .jump(id_jump)
  );

  register_file register_file_i (
    .clk(clk), .rst_n(rst_n),
    .read_addr_1(id_rs), .read_addr_2(id_rt),
    .read_data_1(id_read_data_1), .read_data_2(id_read_data_2),
    .write_en(wb_reg_write), .write_addr(wb_dest_reg), .write_data(wb_data)
  );

  hazard_unit hazard_i (
    .if_id_rs(id_rs), .if_id_rt(id_rt),
    .id_ex_rt(ex_rt), .id_ex_mem_op(ex_mem_op),
    .ex_rs(ex_rs), .ex_rt(ex_rt),
    .mem_dest(mem_dest_reg), .mem_reg_write(mem_reg_write),
    .wb_dest(wb_dest_reg), .wb_reg_write(wb_reg_write),
    .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  id_ex_register id_ex_i (
    .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
    .rs_in(id_rs), .rs_out(ex_rs),
    .rt_in(id_rt), .rt_out(ex_rt),
    .rd_in(id_rd), .rd_out(ex_rd),
    .read_data_1_in(id_read_data_1), .read_data_1_out(ex_read_data_1),
    .read_data_2_in(id_read_data_2), .read_data_2_out(ex_read_data_2),
    .immediate_in(id_immediate), .immediate_out(ex_immediate),
    .target_in(id_target), .target_out(ex_target),
    .alu_op_in(id_alu_op), .alu_op_out(ex_alu_op),
    .mem_op_in(id_mem_op), .mem_op_out(ex_mem_op),
    .alu_src_in(id_alu_src), .alu_src_out(ex_alu_src),
    .reg_dst_in(id_reg_dst), .reg_dst_out(ex_reg_dst),
    .reg_write_in(id_reg_write), .reg_write_out(ex_reg_write),
    .beq_in(id_beq), .beq_out(ex_beq),
    .bne_in(id_bne), .bne_out(ex_bne),
    .jump_in(id_jump), .jump_out(ex_jump)
  );

  execute_unit execute_i (
    .fwd_a(fwd_a), .fwd_b(fwd_b),
    .read_data_1(ex_read_data_1), .read_data_2(ex_read_data_2),
    .mem_result(mem_alu_result), .wb_result(wb_data),
    .immediate(ex_immediate), .alu_op(ex_alu_op), .alu_src(ex_alu_src),
    .reg_dst(ex_reg_dst), .rt(ex_rt), .rd(ex_rd),
    .beq(ex_beq), .bne(ex_bne), .jump(ex_jump),
    .alu_result(ex_alu_result), .store_data(ex_store_data),
    .dest_reg(ex_dest_reg), .take_branch(ex_take_branch)
  );

  ex_mem_register ex_mem_i (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .alu_result_in(ex_alu_result), .alu_result_out(mem_alu_result),
    .store_data_in(ex_store_data), .store_data_out(mem_store_data),
    .dest_reg_in(ex_dest_reg), .dest_reg_out(mem_dest_reg),
    .mem_op_in(ex_mem_op), .mem_op_out(mem_mem_op),
    .reg_write_in(ex_reg_write), .reg_write_out(mem_reg_write),
    .take_branch_in(ex_take_branch), .take_branch_out(mem_take_branch),
    .target_in(ex_target), .target_out(mem_target)
  );

  mem_wb_register mem_wb_i (
    .clk(clk), .rst_n(rst_n),
    .wb_data_in(mem_wb_data), .wb_data_out(wb_data),
    .dest_reg_in(mem_dest_reg), .dest_reg_out(wb_dest_reg),
    .reg_write_in(mem_reg_write), .reg_write_out(wb_reg_write)
  );

endmodule

// ==== verilog/cpu_pkg.sv ====
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef enum logic [3:0] {
    OP_RTYPE = 4'd0,
    OP_ADDI  = 4'd1,
    OP_LW    = 4'd2,
    OP_SW    = 4'd3,
    OP_BEQ   = 4'd4,
    OP_BNE   = 4'd5,
    OP_JMP   = 4'd6
  } opcode_t;

  // order matches the r-type funct field.
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_t;

  typedef enum logic [1:0] {MEM_NONE, MEM_READ, MEM_WRITE} mem_op_t;

  typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;

  typedef union packed {
    struct packed {
      opcode_t                opcode;
      logic [`REG_ADDR_W-1:0] rs;
      logic [`REG_ADDR_W-1:0] rt;
      logic [`REG_ADDR_W-1:0] rd;
      logic [2:0]             funct;
    } r;
    struct packed {
      opcode_t                opcode;
      logic [`REG_ADDR_W-1:0] rs;
      logic [`REG_ADDR_W-1:0] rt;
      logic signed [5:0]      imm;
    } i;
    struct packed {
      opcode_t     opcode;
      logic [11:0] addr;    // absolute word address.
    } j;
  } instr_t;

endpackage

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module decode_unit import cpu_pkg::*; (
  input  instr_t                 instr,
  input  logic [`DATA_W-1:0]     pc_next,
  output logic [`REG_ADDR_W-1:0] rs,
  output logic [`REG_ADDR_W-1:0] rt,
  output logic [`REG_ADDR_W-1:0] rd,
  output logic [`DATA_W-1:0]     immediate,
  output logic [`DATA_W-1:0]     target,
  output alu_op_t                alu_op,
  output mem_op_t                mem_op,
  output logic                   alu_src,
  output logic                   reg_dst,
  output logic                   reg_write,
  output logic                   beq,
  output logic                   bne,
  output logic                   jump
);

  assign rs = instr.r.rs;
  assign rt = instr.r.rt;
  assign rd = instr.r.rd;
  assign immediate = {{(`DATA_W-6){instr.i.imm[5]}}, instr.i.imm};

  // branches are relative to the following instruction, jumps are absolute.
  assign target = jump ? {{(`DATA_W-12){1'b0}}, instr.j.addr} : pc_next + immediate;

  always_comb begin
    alu_op    = ALU_ADD;
    mem_op    = MEM_NONE;
    alu_src   = 1'b0;
    reg_dst   = 1'b0;
    reg_write = 1'b0;
    beq       = 1'b0;
    bne       = 1'b0;
    jump      = 1'b0;
    case (instr.r.opcode)
      OP_RTYPE: begin
        if (instr.r.funct <= 3'd5) begin    // funct 6 and 7 are left undecoded.
          alu_op    = alu_op_t'({1'b0, instr.r.funct});
          reg_dst   = 1'b1;
          reg_write = 1'b1;
        end
      end
      OP_ADDI: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      OP_LW: begin
        alu_src   = 1'b1;
        mem_op    = MEM_READ;
        reg_write = 1'b1;
      end
      OP_SW: begin
        alu_src = 1'b1;
        mem_op  = MEM_WRITE;
      end
      OP_BEQ: beq = 1'b1;
      OP_BNE: bne = 1'b1;
      OP_JMP: jump = 1'b1;
      default: ;
    endcase
  end

endmodule

// ==== verilog/execute_unit.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module execute_unit import cpu_pkg::*; (
  input  fwd_sel_t               fwd_a,
  input  fwd_sel_t               fwd_b,
  input  logic [`DATA_W-1:0]     read_data_1,
  input  logic [`DATA_W-1:0]     read_data_2,
  input  logic [`DATA_W-1:0]     mem_result,
  input  logic [`DATA_W-1:0]     wb_result,
  input  logic [`DATA_W-1:0]     immediate,
  input  alu_op_t                alu_op,
  input  logic                   alu_src,
  input  logic                   reg_dst,
  input  logic [`REG_ADDR_W-1:0] rt,
  input  logic [`REG_ADDR_W-1:0] rd,
  input  logic                   beq,
  input  logic                   bne,
  input  logic                   jump,
  output logic [`DATA_W-1:0]     alu_result,
  output logic [`DATA_W-1:0]     store_data,
  output logic [`REG_ADDR_W-1:0] dest_reg,
  output logic                   take_branch
);

  logic [`DATA_W-1:0] operand_a;
  logic [`DATA_W-1:0] operand_b;
  logic [`DATA_W-1:0] alu_b;

  function automatic logic [`DATA_W-1:0] forward(input fwd_sel_t sel,
                                                 input logic [`DATA_W-1:0] reg_val);
    case (sel)
      FWD_MEM: return mem_result;
      FWD_WB:  return wb_result;
      default: return reg_val;
    endcase
  endfunction

  always_comb begin
    operand_a = forward(fwd_a, read_data_1);
    operand_b = forward(fwd_b, read_data_2);
  end

  assign alu_b      = alu_src ? immediate : operand_b;
  assign store_data = operand_b;              // sw stores rt.
  assign dest_reg   = reg_dst ? rd : rt;

  always_comb begin
    case (alu_op)
      ALU_SUB: alu_result = operand_a - alu_b;
      ALU_AND: alu_result = operand_a & alu_b;
      ALU_OR:  alu_result = operand_a | alu_b;
      ALU_XOR: alu_result = operand_a ^ alu_b;
      ALU_SLT: alu_result = {{(`DATA_W-1){1'b0}}, $signed(operand_a) < $signed(alu_b)};
      default: alu_result = operand_a + alu_b;
    endcase
  end

  // branches compare the two register operands, never the immediate.
  assign take_branch = jump ||
                       (beq && operand_a == operand_b) ||
                       (bne && operand_a != operand_b);

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module hazard_unit import cpu_pkg::*; (
  input  logic [`REG_ADDR_W-1:0] if_id_rs,
  input  logic [`REG_ADDR_W-1:0] if_id_rt,
  input  logic [`REG_ADDR_W-1:0] id_ex_rt,
  input  mem_op_t                id_ex_mem_op,
  input  logic [`REG_ADDR_W-1:0] ex_rs,
  input  logic [`REG_ADDR_W-1:0] ex_rt,
  input  logic [`REG_ADDR_W-1:0] mem_dest,
  input  logic                   mem_reg_write,
  input  logic [`REG_ADDR_W-1:0] wb_dest,
  input  logic                   wb_reg_write,
  output logic                   stall,
  output fwd_sel_t               fwd_a,
  output fwd_sel_t               fwd_b
);

  // the younger producer wins, so the memory stage is checked first.
  function automatic fwd_sel_t pick_source(input logic [`REG_ADDR_W-1:0] src);
    if (mem_reg_write && mem_dest == src)
      return FWD_MEM;
    if (wb_reg_write && wb_dest == src)
      return FWD_WB;
    return FWD_REG;
  endfunction

  // a load result is only ready after the memory stage, one cycle too late.
  assign stall = (id_ex_mem_op == MEM_READ) &&
                 (id_ex_rt == if_id_rs || id_ex_rt == if_id_rt);

  always_comb begin
    fwd_a = pick_source(ex_rs);
    fwd_b = pick_source(ex_rt);
  end

endmodule

// ==== verilog/pipeline_regs.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module if_id_register (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall,
  input  logic               flush,
  input  logic [`DATA_W-1:0] instr_in,
  input  logic [`DATA_W-1:0] pc_next_in,
  output logic [`DATA_W-1:0] instr_out,
  output logic [`DATA_W-1:0] pc_next_out
);

  // opcode 4'hf has no decode, so this word does nothing.
  localparam logic [`DATA_W-1:0] NOP = {4'hf, {(`DATA_W-4){1'b0}}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr_out   <= NOP;
      pc_next_out <= '0;
    end else if (flush) begin
      instr_out   <= NOP;
      pc_next_out <= '0;
    end else if (!stall) begin
      instr_out   <= instr_in;
      pc_next_out <= pc_next_in;
    end
  end

endmodule

module id_ex_register import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   stall,
  input  logic                   flush,
  input  logic [`REG_ADDR_W-1:0] rs_in,
  input  logic [`REG_ADDR_W-1:0] rt_in,
  input  logic [`REG_ADDR_W-1:0] rd_in,
  input  logic [`DATA_W-1:0]     read_data_1_in,
  input  logic [`DATA_W-1:0]     read_data_2_in,
  input  logic [`DATA_W-1:0]     immediate_in,
  input  logic [`DATA_W-1:0]     target_in,
  input  alu_op_t                alu_op_in,
  input  mem_op_t                mem_op_in,
  input  logic                   alu_src_in,
  input  logic                   reg_dst_in,
  input  logic                   reg_write_in,
  input  logic                   beq_in,
  input  logic                   bne_in,
  input  logic                   jump_in,
  output logic [`REG_ADDR_W-1:0] rs_out,
  output logic [`REG_ADDR_W-1:0] rt_out,
  output logic [`REG_ADDR_W-1:0] rd_out,
  output logic [`DATA_W-1:0]     read_data_1_out,
  output logic [`DATA_W-1:0]     read_data_2_out,
  output logic [`DATA_W-1:0]     immediate_out,
  output logic [`DATA_W-1:0]     target_out,
  output alu_op_t                alu_op_out,
  output mem_op_t                mem_op_out,
  output logic                   alu_src_out,
  output logic                   reg_dst_out,
  output logic                   reg_write_out,
  output logic                   beq_out,
  output logic                   bne_out,
  output logic                   jump_out
);

  logic bubble;

  assign bubble = stall || flush;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_op_out    <= ALU_ADD;
      mem_op_out    <= MEM_NONE;
      alu_src_out   <= 1'b0;
      reg_dst_out   <= 1'b0;
      reg_write_out <= 1'b0;
      beq_out       <= 1'b0;
      bne_out       <= 1'b0;
      jump_out      <= 1'b0;
    end else begin
      alu_op_out    <= bubble ? ALU_ADD : alu_op_in;
      mem_op_out    <= bubble ? MEM_NONE : mem_op_in;
      alu_src_out   <= alu_src_in && !bubble;
      reg_dst_out   <= reg_dst_in && !bubble;
      reg_write_out <= reg_write_in && !bubble;
      beq_out       <= beq_in && !bubble;
      bne_out       <= bne_in && !bubble;
      jump_out      <= jump_in && !bubble;
    end
  end

  // a bubble carries stale operands, which are harmless without control.
  always_ff @(posedge clk) begin
    rs_out          <= rs_in;
    rt_out          <= rt_in;
    rd_out          <= rd_in;
    read_data_1_out <= read_data_1_in;
    read_data_2_out <= read_data_2_in;
    immediate_out   <= immediate_in;
    target_out      <= target_in;
  end

endmodule

module ex_mem_register import cpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush,
  input  logic [`DATA_W-1:0]     alu_result_in,
  input  logic [`DATA_W-1:0]     store_data_in,
  input  logic [`REG_ADDR_W-1:0] dest_reg_in,
  input  mem_op_t                mem_op_in,
  input  logic                   reg_write_in,
  input  logic                   take_branch_in,
  input  logic [`DATA_W-1:0]     target_in,
  output logic [`DATA_W-1:0]     alu_result_out,
  output logic [`DATA_W-1:0]     store_data_out,
  output logic [`REG_ADDR_W-1:0] dest_reg_out,
  output mem_op_t                mem_op_out,
  output logic                   reg_write_out,
  output logic                   take_branch_out,
  output logic [`DATA_W-1:0]     target_out
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_op_out      <= MEM_NONE;
      reg_write_out   <= 1'b0;
      take_branch_out <= 1'b0;
    end else begin
      mem_op_out      <= flush ? MEM_NONE : mem_op_in;
      reg_write_out   <= reg_write_in && !flush;
      take_branch_out <= take_branch_in && !flush;
    end
  end

  always_ff @(posedge clk) begin
    alu_result_out <= alu_result_in;
    store_data_out <= store_data_in;
    dest_reg_out   <= dest_reg_in;
    target_out     <= target_in;
  end

endmodule

module mem_wb_register (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`DATA_W-1:0]     wb_data_in,
  input  logic [`REG_ADDR_W-1:0] dest_reg_in,
  input  logic                   reg_write_in,
  output logic [`DATA_W-1:0]     wb_data_out,
  output logic [`REG_ADDR_W-1:0] dest_reg_out,
  output logic                   reg_write_out
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      reg_write_out <= 1'b0;
    else
      reg_write_out <= reg_write_in;
  end

  always_ff @(posedge clk) begin
    wb_data_out  <= wb_data_in;
    dest_reg_out <= dest_reg_in;
  end

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module register_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`REG_ADDR_W-1:0] read_addr_1,
  input  logic [`REG_ADDR_W-1:0] read_addr_2,
  output logic [`DATA_W-1:0]     read_data_1,
  output logic [`DATA_W-1:0]     read_data_2,
  input  logic                   write_en,
  input  logic [`REG_ADDR_W-1:0] write_addr,
  input  logic [`DATA_W-1:0]     write_data
);

  logic [`DATA_W-1:0] regs [`NUM_REGS];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
    end else if (write_en) begin
      regs[write_addr] <= write_data;   // r0 is writable like any other.
    end
  end

  // write-through lets decode see the value written back in the same cycle.
  assign read_data_1 = (write_en && write_addr == read_addr_1) ? write_data
                                                               : regs[read_addr_1];
  assign read_data_2 = (write_en && write_addr == read_addr_2) ? write_data
                                                               : regs[read_addr_2];

endmodule
